// File: verilog/multPkg.sv
`default_nettype none

package multPkg;

    // operand and result sizes
    localparam int operandWidth = 8;                  // multiplier and multiplicand
    localparam int productWidth = 2 * operandWidth;   // A concatenated with B
    localparam int iterCount    = operandWidth;       // one add-shift step per bit
    localparam int countWidth   = $clog2(iterCount);  // iteration counter bits

    // control FSM states
    typedef enum logic [2:0] {
        stIdle,     // waiting for the first run edge
        stClear,    // clear X and A, reset the counter
        stAdd,      // add multiplicand into X:A
        stSub,      // subtract multiplicand on the sign bit
        stShift,    // arithmetic shift of X:A:B
        stDone      // product valid, held until the next run
    } ctrlState;

    // ALU opcode
    typedef enum logic {
        opAdd,
        opSub
    } aluOp;

endpackage

`default_nettype wire

// File: verilog/operandInput.sv
`timescale 1ns/1ns
`default_nettype none

module operandInput import multPkg::*; (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic                    loadB,
    input  logic [operandWidth-1:0] switches,
    input  logic                    busy,
    output logic                    startPulse,
    output logic                    loadStrobe,
    output logic [operandWidth-1:0] mcand
);

    logic runQ;      // run from the previous cycle
    logic runEdge;   // accepted rising edge of run
    logic locked;    // inputs ignored while set

    // the FSM is still idle in the startPulse cycle, so block there as well
    assign locked = busy | startPulse;

    assign runEdge    = run & ~runQ & ~locked;
    assign loadStrobe = loadB & ~locked;    // qualified load of B

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            runQ       <= 1'b0;
            startPulse <= 1'b0;
        end else begin
            runQ       <= run;      // tracks run while busy so edges there are lost
            startPulse <= runEdge;  // one cycle after the edge
        end
    end

    // multiplicand taken from the switches in the edge cycle
    always_ff @(posedge Clk) begin
        if (runEdge) begin
            mcand <= switches;
        end
    end

endmodule

`default_nettype wire

// File: verilog/multControl.sv
`timescale 1ns/1ns
`default_nettype none

module multControl import multPkg::*; (
    input  logic Clk,
    input  logic rstN,
    input  logic startPulse,
    input  logic bLsb,
    output logic clearXA,
    output logic loadSum,
    output logic shiftEn,
    output aluOp op,
    output logic busy,
    output logic done
);

    ctrlState state, nextState;
    logic [countWidth-1:0] iterCnt;   // shifts done so far
    logic lastShift;                  // current shift is the final one
    logic lastBitNext;                // bit after this shift is the sign bit

    assign lastShift   = (iterCnt == countWidth'(iterCount - 1));
    assign lastBitNext = (iterCnt == countWidth'(iterCount - 2));

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            iterCnt <= '0;
        end else if (state == stClear) begin
            iterCnt <= '0;
        end else if (state == stShift) begin
            iterCnt <= iterCnt + 1'b1;    // wraps back to 0 after the last shift
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            stIdle: begin
                if (startPulse) begin
                    nextState = stClear;
                end
            end
            stClear: begin
                // first bit is never the sign bit
                nextState = bLsb ? stAdd : stShift;
            end
            stAdd: begin
                nextState = stShift;
            end
            stSub: begin
                nextState = stShift;
            end
            stShift: begin
                // bLsb already shows the bit this shift brings down
                if (lastShift) begin
                    nextState = stDone;
                end else if (bLsb && lastBitNext) begin
                    nextState = stSub;
                end else if (bLsb) begin
                    nextState = stAdd;
                end else begin
                    nextState = stShift;
                end
            end
            stDone: begin
                if (startPulse) begin
                    nextState = stClear;    // product dropped on the next run
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    // Moore outputs
    always_comb begin
        clearXA = 1'b0;
        loadSum = 1'b0;
        shiftEn = 1'b0;
        op      = opAdd;
        unique case (state)
            stClear: clearXA = 1'b1;
            stAdd:   loadSum = 1'b1;
            stSub: begin
                loadSum = 1'b1;
                op      = opSub;    // weight of the sign bit is negative
            end
            stShift: shiftEn = 1'b1;
            default: ;
        endcase
    end

    assign busy = (state != stIdle) && (state != stDone);
    assign done = (state == stDone);

endmodule

`default_nettype wire

// File: verilog/addSub9.sv
`timescale 1ns/1ns
`default_nettype none

module addSub9 import multPkg::*; (
    input  logic                    accX,
    input  logic [operandWidth-1:0] accA,
    input  logic [operandWidth-1:0] mcand,
    input  aluOp                    op,
    output logic [operandWidth-1:0] sum,
    output logic                    sumX
);

    logic [operandWidth:0] accExt;     // X:A, X is the sign of A
    logic [operandWidth:0] mcandExt;   // sign-extended multiplicand
    logic [operandWidth:0] operandB;   // multiplicand or its complement
    logic                  carryIn;
    logic [operandWidth:0] result;

    assign accExt   = {accX, accA};
    assign mcandExt = {mcand[operandWidth-1], mcand};

    // subtract as add of the two's complement
    assign carryIn  = (op == opSub);
    assign operandB = carryIn ? ~mcandExt : mcandExt;

    // nine bits hold any sum of two 8-bit signed values
    assign result = accExt + operandB + {{operandWidth{1'b0}}, carryIn};

    assign sum  = result[operandWidth-1:0];
    assign sumX = result[operandWidth];

endmodule

`default_nettype wire

// File: verilog/productReg.sv
`timescale 1ns/1ns
`default_nettype none

module productReg import multPkg::*; (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    clearXA,
    input  logic                    loadStrobe,
    input  logic                    loadSum,
    input  logic                    shiftEn,
    input  logic [operandWidth-1:0] sum,
    input  logic                    sumX,
    input  logic [operandWidth-1:0] switches,
    output logic                    accX,
    output logic [operandWidth-1:0] accA,
    output logic                    bLsb,
    output logic [productWidth-1:0] product,
    output logic                    sign
);

    logic                    xReg;   // sign extension of A
    logic [operandWidth-1:0] aReg;   // accumulator, upper product half
    logic [operandWidth-1:0] bReg;   // multiplier, lower product half

    // the strobes come from disjoint states, loadStrobe only while idle
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            xReg <= 1'b0;
            aReg <= '0;
            bReg <= '0;
        end else if (loadStrobe) begin
            xReg <= 1'b0;
            aReg <= '0;
            bReg <= switches;    // new multiplier
        end else if (clearXA) begin
            xReg <= 1'b0;
            aReg <= '0;
        end else if (loadSum) begin
            xReg <= sumX;
            aReg <= sum;
        end else if (shiftEn) begin
            // arithmetic shift of X:A:B, X keeps the sign
            aReg <= {xReg, aReg[operandWidth-1:1]};
            bReg <= {aReg[0], bReg[operandWidth-1:1]};
        end
    end

    // lsb as it stands after a shift in progress
    assign bLsb = shiftEn ? bReg[1] : bReg[0];

    assign accX    = xReg;
    assign accA    = aReg;
    assign product = {aReg, bReg};
    assign sign    = xReg;

endmodule

`default_nettype wire

// File: verilog/multiplier.sv
`timescale 1ns/1ns
`default_nettype none

module multiplier import multPkg::*; (
    input  logic                    Clk,
    input  logic                    rstN,
    input  logic                    run,
    input  logic                    loadB,
    input  logic [operandWidth-1:0] switches,
    output logic [productWidth-1:0] product,
    output logic                    sign,
    output logic                    done
);

    logic                    startPulse;
    logic                    loadStrobe;
    logic [operandWidth-1:0] mcand;      // latched multiplicand
    logic                    clearXA;
    logic                    loadSum;
    logic                    shiftEn;
    aluOp                    op;
    logic                    busy;
    logic                    bLsb;
    logic                    accX;
    logic [operandWidth-1:0] accA;
    logic [operandWidth-1:0] sum;
    logic                    sumX;

    operandInput inputSide (
        .Clk        (Clk),
        .rstN       (rstN),
        .run        (run),
        .loadB      (loadB),
        .switches   (switches),
        .busy       (busy),
        .startPulse (startPulse),
        .loadStrobe (loadStrobe),
        .mcand      (mcand)
    );

    multControl control (
        .Clk        (Clk),
        .rstN       (rstN),
        .startPulse (startPulse),
        .bLsb       (bLsb),
        .clearXA    (clearXA),
        .loadSum    (loadSum),
        .shiftEn    (shiftEn),
        .op         (op),
        .busy       (busy),
        .done       (done)
    );

    addSub9 alu (
        .accX  (accX),
        .accA  (accA),
        .mcand (mcand),
        .op    (op),
        .sum   (sum),
        .sumX  (sumX)
    );

    productReg outputSide (
        .Clk        (Clk),
        .rstN       (rstN),
        .clearXA    (clearXA),
        .loadStrobe (loadStrobe),
        .loadSum    (loadSum),
        .shiftEn    (shiftEn),
        .sum        (sum),
        .sumX       (sumX),
        .switches   (switches),
        .accX       (accX),
        .accA       (accA),
        .bLsb       (bLsb),
        .product    (product),
        .sign       (sign)
    );

endmodule

`default_nettype wire

// File: tests/multiplier_props.sv
`timescale 1ns/1ns
`default_nettype none

module multiplier_props import multPkg::*; (
    input logic     Clk,
    input logic     rstN,
    input logic     startPulse,
    input logic     clearXA,
    input logic     loadSum,
    input logic     shiftEn,
    input logic     busy,
    input logic     done,
    input ctrlState state
);

    int failCount = 0;    // summed into the testbench error count

    sumShiftExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(loadSum && shiftEn))
        else begin
            failCount++;
            $error("loadSum and shiftEn high in the same cycle");
        end

    doneNotBusy: assert property (@(posedge Clk) disable iff (!rstN)
        done |-> !busy)
        else begin
            failCount++;
            $error("done and busy high in the same cycle");
        end

    // an accepted start from idle always clears X and A first
    startClears: assert property (@(posedge Clk) disable iff (!rstN)
        (startPulse && state == stIdle) |=> clearXA)
        else begin
            failCount++;
            $error("startPulse in idle not followed by clearXA");
        end

endmodule

`default_nettype wire

// File: tests/multiplierTb.sv
`timescale 1ns/1ns
`default_nettype none

module multiplierTb import multPkg::*; ();

    localparam int doneTimeout = 40;    // cycles per wait on done
    localparam int holdCycles  = 20;
    localparam int numVectors  = 22;
    localparam int numRandom   = 16;

    logic                    Clk;
    logic                    rstN;
    logic                    run;
    logic                    loadB;
    logic [operandWidth-1:0] switches;
    logic [productWidth-1:0] product;
    logic                    sign;
    logic                    done;

    logic [31:0] stimMem [numVectors];   // {multiplier, multiplicand, product}
    logic [31:0] lfsrState;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          testErrStart;

    initial Clk = 1'b0;
    always #50 Clk = ~Clk;    // 100 ns period

    multiplier DUT (
        .Clk      (Clk),
        .rstN     (rstN),
        .run      (run),
        .loadB    (loadB),
        .switches (switches),
        .product  (product),
        .sign     (sign),
        .done     (done)
    );

    bind multControl multiplier_props props (
        .Clk        (Clk),
        .rstN       (rstN),
        .startPulse (startPulse),
        .clearXA    (clearXA),
        .loadSum    (loadSum),
        .shiftEn    (shiftEn),
        .busy       (busy),
        .done       (done),
        .state      (state)
    );

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic drawByte(output logic [operandWidth-1:0] value);
        value = '0;
        for (int i = 0; i < operandWidth; i++) begin
            value     = {value[operandWidth-2:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);    // one step per bit
        end
    endtask

    function automatic logic signed [productWidth-1:0] signedProduct(
        input logic [operandWidth-1:0] a,
        input logic [operandWidth-1:0] b
    );
        logic signed [productWidth-1:0] aExt;
        logic signed [productWidth-1:0] bExt;
        aExt = {{operandWidth{a[operandWidth-1]}}, a};
        bExt = {{operandWidth{b[operandWidth-1]}}, b};
        return aExt * bExt;
    endfunction

    task automatic checkProduct(input logic signed [productWidth-1:0] got,
                                input logic signed [productWidth-1:0] expected,
                                input string name);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic checkFlag(input logic got, input logic expected, input string name);
        if (got !== expected) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    task automatic startTest();
        testErrStart = errorCount;
        testCount++;
    endtask

    task automatic reportTest(input string name);
        if (errorCount == testErrStart) begin
            $display("test %0d %s: pass", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: FAIL", testCount, name);
        end
    endtask

    task automatic waitDone(input logic level, output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < doneTimeout) begin
            @(negedge Clk);    // outputs settled
            ok = (done === level);
            cycles++;
        end
        if (!ok) begin
            $display("timeout: done did not go to %0d within %0d cycles", level, doneTimeout);
            errorCount++;
        end
    endtask

    task automatic loadMultiplier(input logic [operandWidth-1:0] value);
        @(posedge Clk);
        switches <= value;
        loadB    <= 1'b1;
        @(posedge Clk);
        loadB    <= 1'b0;
    endtask

    task automatic startRun(input logic [operandWidth-1:0] value);
        @(posedge Clk);
        switches <= value;    // multiplicand taken in the edge cycle
        run      <= 1'b1;
        @(posedge Clk);
        run      <= 1'b0;
    endtask

    task automatic multiplyAndCheck(input logic [operandWidth-1:0] mult,
                                    input logic [operandWidth-1:0] mcand,
                                    input logic signed [productWidth-1:0] expected);
        logic ok;
        loadMultiplier(mult);
        startRun(mcand);
        waitDone(1'b0, ok);    // old done drops first
        if (ok) begin
            waitDone(1'b1, ok);
        end
        if (ok) begin
            checkProduct(product, expected, "product");
            checkFlag(sign, expected[productWidth-1], "sign");
        end
    endtask

    initial begin
        logic [31:0]                    vec;
        logic [operandWidth-1:0]        mult;
        logic [operandWidth-1:0]        mcand;
        logic signed [productWidth-1:0] expProduct;
        logic                           ok;
        rstN        = 1'b0;
        run         = 1'b0;
        loadB       = 1'b0;
        switches    = '0;
        lfsrState   = 32'hef8f;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        for (int i = 0; i < numVectors; i++) begin
            stimMem[i] = 'x;
        end
        $readmemh("tests/multiplier_stim.txt", stimMem);

        repeat (16) @(posedge Clk);
        rstN <= 1'b1;

        startTest();
        @(negedge Clk);
        checkFlag(done, 1'b0, "done");
        checkFlag(sign, 1'b0, "sign");
        checkProduct(product, '0, "product");
        reportTest("reset state");

        for (int i = 0; i < numVectors; i++) begin
            vec = stimMem[i];
            startTest();
            if ($isunknown(vec)) begin
                $display("stimulus vector %0d is missing from the data file", i);
                errorCount++;
            end else begin
                multiplyAndCheck(vec[31:24], vec[23:16], vec[15:0]);
            end
            reportTest($sformatf("vector %0d", i));
        end

        for (int i = 0; i < numRandom; i++) begin
            drawByte(mult);
            drawByte(mcand);
            startTest();
            multiplyAndCheck(mult, mcand, signedProduct(mcand, mult));
            reportTest($sformatf("random %0d (0x%h x 0x%h)", i, mcand, mult));
        end

        // second load and second run edge land while the first run is busy
        startTest();
        mult       = 8'h6d;
        mcand      = 8'h93;
        expProduct = signedProduct(mcand, mult);
        loadMultiplier(mult);
        startRun(mcand);
        repeat (2) @(posedge Clk);
        loadMultiplier(8'h00);
        startRun(8'h7f);
        waitDone(1'b0, ok);
        if (ok) begin
            waitDone(1'b1, ok);
        end
        if (ok) begin
            checkProduct(product, expProduct, "product");
            checkFlag(sign, expProduct[productWidth-1], "sign");
        end
        reportTest("inputs ignored while busy");

        startTest();
        for (int i = 0; i < holdCycles; i++) begin
            @(negedge Clk);
            checkFlag(done, 1'b1, "done");
            checkProduct(product, expProduct, "product");
            checkFlag(sign, expProduct[productWidth-1], "sign");
        end
        startRun(8'h11);
        waitDone(1'b0, ok);    // next edge drops done
        if (ok) begin
            waitDone(1'b1, ok);
        end
        reportTest("done holds until next run");

        errorCount += DUT.control.props.failCount;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d, errors %0d",
                 testCount, testCount - failedTests, failedTests,
                 DUT.control.props.failCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: multiplier.f
verilog/multPkg.sv
verilog/operandInput.sv
verilog/multControl.sv
verilog/addSub9.sv
verilog/productReg.sv
verilog/multiplier.sv
tests/multiplier_props.sv
tests/multiplierTb.sv

// File: Bender.yml
package:
  name: multiplier

sources:
  - verilog/multPkg.sv
  - verilog/operandInput.sv
  - verilog/multControl.sv
  - verilog/addSub9.sv
  - verilog/productReg.sv
  - verilog/multiplier.sv
  - target: test
    files:
      - tests/multiplier_props.sv
      - tests/multiplierTb.sv

// File: tests/multiplier_stim.txt
// columns: multiplier, multiplicand, expected signed product (hex)
// one packed word per line: {multiplier[7:0], multiplicand[7:0], product[15:0]}
00000000
007f0000
7f000000
01010001
01ffffff
ff01ffff
ffff0001
7f7f3f01
80804000
807fc080
7f80c080
8001ff80
0180ff80
80ff0080
ff800080
0503000f
fb03fff1
05fdfff1
fbfd000f
55aae372
aa55e372
649cd8f0
